// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// ram depth in words, index taken from address bits above the byte offset
	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// memory operation codes seen at the core side
	typedef enum logic [2:0] {
		MEM_NONE = 3'd0,
		MEM_LB   = 3'd1,
		MEM_LH   = 3'd2,
		MEM_LW   = 3'd3,
		MEM_SB   = 3'd4,
		MEM_SH   = 3'd5,
		MEM_SW   = 3'd6
	} mem_op_e;

	// one bus word, seen whole, as byte lanes or as half lanes
	typedef union packed {
		logic [DATA_W-1:0]             word;
		logic [STRB_W-1:0][7:0]        bytes;
		logic [STRB_W/2-1:0][15:0]     halves;
	} mem_word_u;

endpackage

// ==== rtl/axi_lite_if.sv ====
interface axi_lite_if;
	import lsu_pkg::*;

	// write address and write data
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;

	// write response, always okay
	logic              bvalid;
	logic              bready;

	// read address and read data
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic              rvalid;
	logic              rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input  awready, wready, bvalid, arready, rdata, rvalid
	);

	modport slave (
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bvalid, arready, rdata, rvalid
	);

endinterface

// ==== rtl/lsu_cmd_if.sv ====
interface lsu_cmd_if;
	import lsu_pkg::*;

	logic              valid;
	logic              ready;
	logic              write;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;

	// request stage side
	modport source (
		output valid, write, addr, wdata, wstrb,
		input  ready
	);

	// axi master side
	modport sink (
		input  valid, write, addr, wdata, wstrb,
		output ready
	);

endinterface

// ==== rtl/lsu_request.sv ====
module lsu_request (
	input  logic                       axi_aclk_i,
	input  logic                       axi_aresetn_i,
	input  logic                       req_i,
	input  lsu_pkg::mem_op_e           op_i,
	input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
	input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
	input  logic                       done_i,
	output logic                       ack_o,
	output lsu_pkg::mem_op_e           op_o,
	output logic [1:0]                 lane_o,
	lsu_cmd_if.source                  cmd
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT,
		ST_ACK
	} state_e;

	state_e            state_q;
	mem_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	mem_word_u         store_word;
	logic [STRB_W-1:0] store_strb;

	// store data replicated onto every lane, strobe picks the live one
	always_comb begin
		store_word.word = wdata_i;
		store_strb      = '0;
		case (op_i)
			MEM_SB: begin
				store_word.bytes = {STRB_W{wdata_i[7:0]}};
				store_strb       = 4'b0001 << addr_i[1:0];
			end
			MEM_SH: begin
				store_word.halves = {(STRB_W/2){wdata_i[15:0]}};
				// halves only look at address bit 1
				store_strb        = 4'b0011 << {addr_i[1], 1'b0};
			end
			MEM_SW: begin
				store_strb = 4'b1111;
			end
			default: begin
				store_strb = '0;
			end
		endcase
	end

	// four-phase handshake with the core
	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_i) begin
						// nothing to fetch for a none op, just close the handshake
						state_q <= (op_i == MEM_NONE) ? ST_ACK : ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (cmd.ready) begin
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (done_i) begin
						state_q <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!req_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// request captured once, held until the next one
	always_ff @(posedge axi_aclk_i) begin
		if (state_q == ST_IDLE && req_i) begin
			op_q    <= op_i;
			addr_q  <= addr_i;
			wdata_q <= store_word.word;
			wstrb_q <= store_strb;
		end
	end

	assign cmd.valid = (state_q == ST_ISSUE);
	assign cmd.write = (op_q == MEM_SB) || (op_q == MEM_SH) || (op_q == MEM_SW);
	assign cmd.addr  = addr_q;
	assign cmd.wdata = wdata_q;
	assign cmd.wstrb = wstrb_q;

	assign ack_o  = (state_q == ST_ACK);
	assign op_o   = op_q;
	assign lane_o = addr_q[1:0];

endmodule

// ==== rtl/axi_master.sv ====
module axi_master (
	input  logic                       axi_aclk_i,
	input  logic                       axi_aresetn_i,
	lsu_cmd_if.sink                    cmd,
	axi_lite_if.master                 axi,
	output logic                       done_o,
	output logic [lsu_pkg::DATA_W-1:0] rd_data_o
);
	import lsu_pkg::*;

	logic              busy_q;
	logic              ready_q;
	logic              write_q;
	logic              awvalid_q;
	logic              wvalid_q;
	logic              arvalid_q;
	logic              bready_q;
	logic              rready_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;

	logic cmd_fire;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic b_fire;
	logic r_fire;

	assign cmd_fire = cmd.valid && ready_q;
	assign aw_fire  = awvalid_q && axi.awready;
	assign w_fire   = wvalid_q && axi.wready;
	assign ar_fire  = arvalid_q && axi.arready;
	assign b_fire   = axi.bvalid && bready_q;
	assign r_fire   = axi.rvalid && rready_q;

	// a write finishes only once both AW and W have gone through
	assign done_o = busy_q && (write_q ? (b_fire && !awvalid_q && !wvalid_q)
	                                   : (r_fire && !arvalid_q));

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			busy_q    <= 1'b0;
			ready_q   <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
			bready_q  <= 1'b0;
			rready_q  <= 1'b0;
		end else begin
			// responses are always taken
			bready_q <= 1'b1;
			rready_q <= 1'b1;

			if (cmd_fire) begin
				busy_q    <= 1'b1;
				ready_q   <= 1'b0;
				awvalid_q <= cmd.write;
				wvalid_q  <= cmd.write;
				arvalid_q <= !cmd.write;
			end else if (done_o) begin
				busy_q  <= 1'b0;
				ready_q <= 1'b1;
			end else if (!busy_q) begin
				ready_q <= 1'b1;
			end

			// each channel drops its valid on its own handshake
			if (aw_fire) begin
				awvalid_q <= 1'b0;
			end
			if (w_fire) begin
				wvalid_q <= 1'b0;
			end
			if (ar_fire) begin
				arvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge axi_aclk_i) begin
		if (cmd_fire) begin
			write_q <= cmd.write;
			addr_q  <= cmd.addr;
			wdata_q <= cmd.wdata;
			wstrb_q <= cmd.wstrb;
		end
	end

	assign cmd.ready = ready_q;

	assign axi.awaddr  = addr_q;
	assign axi.awvalid = awvalid_q;
	assign axi.wdata   = wdata_q;
	assign axi.wstrb   = wstrb_q;
	assign axi.wvalid  = wvalid_q;
	assign axi.bready  = bready_q;
	assign axi.araddr  = addr_q;
	assign axi.arvalid = arvalid_q;
	assign axi.rready  = rready_q;

	assign rd_data_o = axi.rdata;

endmodule

// ==== rtl/load_extend.sv ====
module load_extend (
	input  logic                       axi_aclk_i,
	input  logic                       axi_aresetn_i,
	input  logic                       done_i,
	input  logic [lsu_pkg::DATA_W-1:0] rd_data_i,
	input  lsu_pkg::mem_op_e           op_i,
	input  logic [1:0]                 lane_i,
	output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
	import lsu_pkg::*;

	mem_word_u rd_word;

	assign rd_word.word = rd_data_i;

	// stores leave the last load result in place
	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			rdata_o <= '0;
		end else if (done_i) begin
			case (op_i)
				MEM_LB: begin
					rdata_o <= {{(DATA_W-8){rd_word.bytes[lane_i][7]}},
					            rd_word.bytes[lane_i]};
				end
				MEM_LH: begin
					// half select ignores lane bit 0
					rdata_o <= {{(DATA_W-16){rd_word.halves[lane_i[1]][15]}},
					            rd_word.halves[lane_i[1]]};
				end
				MEM_LW: begin
					rdata_o <= rd_word.word;
				end
				default: begin
					rdata_o <= rdata_o;
				end
			endcase
		end
	end

endmodule

// ==== rtl/axi_lite_ram.sv ====
module axi_lite_ram (
	input  logic       axi_aclk_i,
	input  logic       axi_aresetn_i,
	axi_lite_if.slave  axi
);
	import lsu_pkg::*;

	logic [DATA_W-1:0]    mem [RAM_WORDS];
	logic                 wr_ready_q;
	logic                 arready_q;
	logic                 bvalid_q;
	logic                 rvalid_q;
	logic [DATA_W-1:0]    rdata_q;
	logic [RAM_IDX_W-1:0] wr_idx;
	logic [RAM_IDX_W-1:0] rd_idx;
	logic                 wr_fire;
	logic                 rd_fire;

	// word index from address bits above the byte offset
	assign wr_idx = axi.awaddr[RAM_IDX_W+1:2];
	assign rd_idx = axi.araddr[RAM_IDX_W+1:2];

	assign wr_fire = axi.awvalid && axi.wvalid && wr_ready_q;
	assign rd_fire = axi.arvalid && arready_q;

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			wr_ready_q <= 1'b0;
			arready_q  <= 1'b0;
			bvalid_q   <= 1'b0;
			rvalid_q   <= 1'b0;
		end else begin
			// AW and W taken together, one cycle after both show up
			wr_ready_q <= axi.awvalid && axi.wvalid && !wr_ready_q && !bvalid_q;
			arready_q  <= axi.arvalid && !arready_q && !rvalid_q;

			if (wr_fire) begin
				bvalid_q <= 1'b1;
			end else if (axi.bready) begin
				bvalid_q <= 1'b0;
			end

			if (rd_fire) begin
				rvalid_q <= 1'b1;
			end else if (axi.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// byte lane writes under strobe
	always_ff @(posedge axi_aclk_i) begin
		if (wr_fire) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (axi.wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= axi.wdata[i*8 +: 8];
				end
			end
		end
		if (rd_fire) begin
			rdata_q <= mem[rd_idx];
		end
	end

	assign axi.awready = wr_ready_q;
	assign axi.wready  = wr_ready_q;
	assign axi.bvalid  = bvalid_q;
	assign axi.arready = arready_q;
	assign axi.rvalid  = rvalid_q;
	assign axi.rdata   = rdata_q;

endmodule

// ==== rtl/mem_subsystem.sv ====
module mem_subsystem (
	input  logic                       axi_aclk_i,
	input  logic                       axi_aresetn_i,
	input  logic                       req_i,
	input  lsu_pkg::mem_op_e           op_i,
	input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
	input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
	import lsu_pkg::*;

	logic              done;
	logic [DATA_W-1:0] rd_data;
	mem_op_e           ld_op;
	logic [1:0]        ld_lane;

	lsu_cmd_if  u_cmd_if ();
	axi_lite_if u_axi_if ();

	// core handshake and store lane setup
	lsu_request u_lsu_request (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.req_i         (req_i),
		.op_i          (op_i),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.done_i        (done),
		.ack_o         (ack_o),
		.op_o          (ld_op),
		.lane_o        (ld_lane),
		.cmd           (u_cmd_if.source)
	);

	axi_master u_axi_master (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.cmd           (u_cmd_if.sink),
		.axi           (u_axi_if.master),
		.done_o        (done),
		.rd_data_o     (rd_data)
	);

	load_extend u_load_extend (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.done_i        (done),
		.rd_data_i     (rd_data),
		.op_i          (ld_op),
		.lane_i        (ld_lane),
		.rdata_o       (rdata_o)
	);

	axi_lite_ram u_axi_lite_ram (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.axi           (u_axi_if.slave)
	);

endmodule

// ==== verif/tb_mem_subsystem.sv ====
module tb_mem_subsystem;
	timeunit 1ns;
	timeprecision 1ps;

	import lsu_pkg::*;

	logic        axi_aclk;
	logic        axi_aresetn;
	logic        req;
	mem_op_e     op;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        ack;
	logic [31:0] rdata;

	// one request per entry, expected rdata_o filled in from the byte model
	mem_op_e     tbl_op [$];
	logic [31:0] tbl_addr [$];
	logic [31:0] tbl_wdata [$];
	logic [31:0] tbl_exp [$];
	int          tbl_hold [$];
	string       tbl_name [$];

	logic [7:0]  ref_mem [1024];
	logic [31:0] last_load;
	logic [31:0] rng;
	int          cycle_count = 0;
	int          cycle_limit;

	mem_subsystem u_dut (
		.axi_aclk_i    (axi_aclk),
		.axi_aresetn_i (axi_aresetn),
		.req_i         (req),
		.op_i          (op),
		.addr_i        (addr),
		.wdata_i       (wdata),
		.ack_o         (ack),
		.rdata_o       (rdata)
	);

	always #50 axi_aclk = ~axi_aclk;

	always @(posedge axi_aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// byte-array model of the ram, also tracks the last load result
	task automatic add_entry(input mem_op_e o, input logic [31:0] a, input logic [31:0] d,
		input int hold, input string name);
		logic [9:0] idx;
		logic [9:0] wbase;
		logic [9:0] hbase;
		idx   = a[9:0];
		wbase = {a[9:2], 2'b00};
		// halves only look at address bit 1
		hbase = {a[9:1], 1'b0};
		case (o)
			MEM_SB: begin
				ref_mem[idx] = d[7:0];
			end
			MEM_SH: begin
				ref_mem[hbase]         = d[7:0];
				ref_mem[hbase + 10'd1] = d[15:8];
			end
			MEM_SW: begin
				ref_mem[wbase]         = d[7:0];
				ref_mem[wbase + 10'd1] = d[15:8];
				ref_mem[wbase + 10'd2] = d[23:16];
				ref_mem[wbase + 10'd3] = d[31:24];
			end
			MEM_LB: begin
				last_load = {{24{ref_mem[idx][7]}}, ref_mem[idx]};
			end
			MEM_LH: begin
				last_load = {{16{ref_mem[hbase + 10'd1][7]}}, ref_mem[hbase + 10'd1],
				             ref_mem[hbase]};
			end
			MEM_LW: begin
				last_load = {ref_mem[wbase + 10'd3], ref_mem[wbase + 10'd2],
				             ref_mem[wbase + 10'd1], ref_mem[wbase]};
			end
			default: begin
			end
		endcase
		tbl_op.push_back(o);
		tbl_addr.push_back(a);
		tbl_wdata.push_back(d);
		tbl_exp.push_back(last_load);
		tbl_hold.push_back(hold);
		tbl_name.push_back(name);
	endtask

	task automatic build_table();
		logic [31:0] word_addr [$];
		logic [31:0] a;
		mem_op_e     o;
		word_addr = '{32'h000, 32'h004, 32'h0a0, 32'h1fc, 32'h200, 32'h3fc};
		for (int i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			add_entry(MEM_SW, word_addr[i], rng, 0, $sformatf("sw_word_%0d", i));
		end
		for (int i = 0; i < 6; i++) begin
			add_entry(MEM_LW, word_addr[i], '0, 0, $sformatf("lw_word_%0d", i));
		end
		// partial stores merged into a known word
		add_entry(MEM_SW, 32'h100, 32'h11223344, 0, "sw_merge_bytes");
		for (int i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			add_entry(MEM_SB, 32'h100 + i, rng, 0, $sformatf("sb_lane_%0d", i));
			add_entry(MEM_LW, 32'h100, '0, 0, $sformatf("lw_after_sb_%0d", i));
		end
		add_entry(MEM_SW, 32'h104, 32'haabbccdd, 0, "sw_merge_halves");
		for (int i = 0; i < 2; i++) begin
			rng = xorshift(rng);
			add_entry(MEM_SH, 32'h104 + 2 * i, rng, 0, $sformatf("sh_half_%0d", i));
			add_entry(MEM_LW, 32'h104, '0, 0, $sformatf("lw_after_sh_%0d", i));
		end
		// lanes 0 and 3 negative, lanes 1 and 2 positive
		add_entry(MEM_SW, 32'h180, 32'h807f01ff, 0, "sw_sign_word");
		for (int i = 0; i < 4; i++) begin
			add_entry(MEM_LB, 32'h180 + i, '0, 0, $sformatf("lb_lane_%0d", i));
		end
		for (int i = 0; i < 4; i++) begin
			add_entry(MEM_LH, 32'h180 + i, '0, 0, $sformatf("lh_addr_%0d", i));
		end
		// core keeps req high past the ack
		add_entry(MEM_LW, 32'h180, '0, 3, "lw_hold_req");
		add_entry(MEM_SW, 32'h1fc, 32'h5a5aa5a5, 5, "sw_hold_req");
		add_entry(MEM_LB, 32'h1fe, '0, 2, "lb_hold_req");
		for (int i = 1; i < 4; i++) begin
			rng = xorshift(rng);
			add_entry(MEM_SW, 32'h200 + 4 * i, rng, 0, $sformatf("sw_mix_init_%0d", i));
		end
		// mixed traffic over four words
		for (int i = 0; i < 24; i++) begin
			rng = xorshift(rng);
			a   = 32'h200 | {28'd0, rng[11:8]};
			case (rng[2:0])
				3'd0: o = MEM_LB;
				3'd1: o = MEM_LH;
				3'd2: o = MEM_LW;
				3'd3: o = MEM_SB;
				3'd4: o = MEM_SH;
				default: begin
					o = MEM_SW;
					a = a & ~32'h3;
				end
			endcase
			add_entry(o, a, {rng[15:0], rng[31:16]}, 0, $sformatf("mix_%0d", i));
		end
	endtask

	// one full four-phase request, entered and left on a falling edge
	task automatic run_entry(input int k);
		op    = tbl_op[k];
		addr  = tbl_addr[k];
		wdata = tbl_wdata[k];
		req   = 1'b1;
		@(negedge axi_aclk);
		assert (ack === 1'b0) else begin
			$display("Error: %s ack_o expected 0 actual %b at request start", tbl_name[k], ack);
			stop_run();
		end
		while (ack !== 1'b1) begin
			@(negedge axi_aclk);
		end
		assert (rdata === tbl_exp[k]) else begin
			$display("Error: %s rdata_o expected %h actual %h", tbl_name[k], tbl_exp[k], rdata);
			stop_run();
		end
		repeat (tbl_hold[k]) begin
			@(negedge axi_aclk);
			assert (ack === 1'b1) else begin
				$display("Error: %s ack_o expected 1 actual %b while req held", tbl_name[k], ack);
				stop_run();
			end
		end
		req = 1'b0;
		@(negedge axi_aclk);
		assert (ack === 1'b0) else begin
			$display("Error: %s ack_o expected 0 actual %b after req drop", tbl_name[k], ack);
			stop_run();
		end
	endtask

	initial begin
		axi_aclk    = 1'b0;
		axi_aresetn = 1'b1;
		req         = 1'b0;
		op          = MEM_NONE;
		addr        = '0;
		wdata       = '0;
		rng         = 32'd14842;
		last_load   = '0;
		build_table();
		cycle_limit = tbl_op.size() * 20 + 50;
		repeat (2) @(negedge axi_aclk);
		axi_aresetn = 1'b0;
		// idle core, no ack expected
		repeat (5) begin
			@(negedge axi_aclk);
			assert (ack === 1'b0) else begin
				$display("Error: idle ack_o expected 0 actual %b", ack);
				stop_run();
			end
		end
		for (int k = 0; k < tbl_op.size(); k++) begin
			run_entry(k);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== sim.f ====
rtl/lsu_pkg.sv
rtl/axi_lite_if.sv
rtl/lsu_cmd_if.sv
rtl/lsu_request.sv
rtl/axi_master.sv
rtl/load_extend.sv
rtl/axi_lite_ram.sv
rtl/mem_subsystem.sv
verif/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f sim.f \
	--top-module tb_mem_subsystem -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	exit 1
fi
exit 0
